/* Makefile */
.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the Verilator build directory"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -Wno-fatal --top-module tb_mandel \
		-f project.f --Mdir obj_dir
	./obj_dir/Vtb_mandel | tee /dev/stderr | grep -q "Everything OK"

clean:
	rm -rf obj_dir

/* bench/tb_clock.sv */
`timescale 1ns/1ps

module tb_clock (
	output logic CLOCK_50,
	output logic arst_n
);
	// 10 ns period, starts low
	initial begin
		CLOCK_50 = 1'b0;
		forever #5 CLOCK_50 = ~CLOCK_50;
	end

	// Reset held over the first 4 rising edges
	// Released on a falling edge, away from the sampling edge
	initial begin
		arst_n = 1'b0;
		repeat (4) @(posedge CLOCK_50);
		@(negedge CLOCK_50);
		arst_n = 1'b1;
	end

endmodule

/* bench/tb_mandel.sv */
`timescale 1ns/1ps
`include "mandel_consts.svh"

module tb_mandel;
	import fixed_pkg::*;
	import pixel_pkg::*;

	// Small frame so a full render stays short
	localparam int frame_w  = 16;
	localparam int frame_h  = 12;
	localparam int lanes    = 3;
	localparam int frame_px = frame_w * frame_h;
	localparam int n_frames = 8;
	// 4.23 constants for the model
	localparam longint one_fx  = longint'(1) << `FRAC_BITS;
	localparam longint two_fx  = 2 * one_fx;
	localparam longint four_fx = 4 * one_fx;

	logic                CLOCK_50;
	logic                arst_n;
	logic                start;
	coord_t              x_init;
	coord_t              y_init;
	logic [`ZOOM_W-1:0]  zoom;
	iter_t               max_iter;
	logic                fb_we;
	fb_addr_t            fb_addr;
	color_t              fb_data;
	logic                done;
	logic [`TIMER_W-1:0] frame_cycles;

	// Model colour per framebuffer address
	color_t      expected_color [frame_px];
	string       test_name;
	// Watchdog budget, reloaded by each new frame
	int unsigned frame_id;
	int unsigned wd_limit;

	tb_clock u_clock (
		.CLOCK_50 (CLOCK_50),
		.arst_n   (arst_n)
	);

	mandel_top #(
		.frame_w (frame_w),
		.frame_h (frame_h),
		.lanes   (lanes)
	) UUT (
		.CLOCK_50     (CLOCK_50),
		.arst_n       (arst_n),
		.start        (start),
		.x_init       (x_init),
		.y_init       (y_init),
		.zoom         (zoom),
		.max_iter     (max_iter),
		.fb_we        (fb_we),
		.fb_addr      (fb_addr),
		.fb_data      (fb_data),
		.done         (done),
		.frame_cycles (frame_cycles)
	);

	// ========================================
	// Reference model
	// ========================================

	// Keep the low 27 bits, sign extended
	function automatic longint wrap_coord(input longint v);
		logic signed [`COORD_W-1:0] w;
		w = v[`COORD_W-1:0];
		return longint'(w);
	endfunction

	// Escape-time count, squares truncated back to 4.23
	function automatic int escape_count(input longint cr, input longint ci, input int limit);
		longint zr;
		longint zi;
		longint zr_sq;
		longint zi_sq;
		longint zr_zi;
		int     n;
		bit     stop;
		zr = 0;
		zi = 0;
		n = 0;
		stop = 1'b0;
		while (!stop) begin
			zr_sq = wrap_coord((zr * zr) >>> `FRAC_BITS);
			zi_sq = wrap_coord((zi * zi) >>> `FRAC_BITS);
			zr_zi = wrap_coord((zr * zi) >>> `FRAC_BITS);
			if (zr_sq + zi_sq >= four_fx || zr >= two_fx || zr <= -two_fx ||
				zi >= two_fx || zi <= -two_fx || n == limit) begin
				stop = 1'b1;
			end else begin
				// Both updates from the old z
				zr = wrap_coord(zr_sq - zi_sq + cr);
				zi = wrap_coord(2 * zr_zi + ci);
				n++;
			end
		end
		return n;
	endfunction

	// Lowest k with n >= limit >> k picks the band
	function automatic color_t band_color(input int n, input int limit);
		color_t pal [1:8];
		color_t c;
		pal = '{`PAL_BAND1, `PAL_BAND2, `PAL_BAND3, `PAL_BAND4,
			`PAL_BAND5, `PAL_BAND6, `PAL_BAND7, `PAL_BAND8};
		c = `PAL_BAND8;
		if (n >= limit) begin
			c = `PAL_BLACK;
		end else begin
			for (int k = 8; k >= 1; k--) begin
				if (n >= (limit >> k))
					c = pal[k];
			end
		end
		return c;
	endfunction

	// Whole frame, point per pixel from the view
	task automatic fill_expected(input longint x, input longint y, input longint dx,
		input longint dy, input int limit);
		longint cr;
		longint ci;
		for (int row = 0; row < frame_h; row++) begin
			for (int col = 0; col < frame_w; col++) begin
				cr = wrap_coord(x + col * dx);
				ci = wrap_coord(y - row * dy);
				expected_color[row * frame_w + col] =
					band_color(escape_count(cr, ci, limit), limit);
			end
		end
	endtask

	// ========================================
	// Checks
	// ========================================
	task automatic stop_with_failure(input string why);
		$display("%s", why);
		$display("Something failed");
		$fatal(1, "Run stopped at the first error");
	endtask

	task automatic check_color(input string what, input color_t expected, input color_t actual);
		if (actual !== expected)
			stop_with_failure($sformatf("[FAIL] %s expected %02h actual %02h",
				what, expected, actual));
	endtask

	task automatic check_addr(input string what, input fb_addr_t expected,
		input fb_addr_t actual);
		if (actual !== expected)
			stop_with_failure($sformatf("[FAIL] %s expected %0d actual %0d",
				what, expected, actual));
	endtask

	task automatic check_cycles(input string what, input logic [`TIMER_W-1:0] expected,
		input logic [`TIMER_W-1:0] actual);
		if (actual !== expected)
			stop_with_failure($sformatf("[FAIL] %s expected %0d actual %0d",
				what, expected, actual));
	endtask

	// No start yet, so nothing may be written
	task automatic idle_check();
		repeat (20) begin
			@(negedge CLOCK_50);
			if (fb_we !== 1'b0 || done !== 1'b0)
				stop_with_failure("fb_we or done went high after reset without a start");
		end
	endtask

	// One frame with a fresh view, then a short hold after done
	task automatic render_frame(input int idx);
		longint x;
		longint y;
		longint dxv;
		longint dyv;
		int     z;
		int     limit;
		int     measured;
		int     writes;
		bit     seen [frame_px];
		// First two frames pin zoom 0 and the two iteration extremes
		z = (idx < 2) ? 0 : int'($urandom % 4);
		limit = (idx == 0) ? 4 : (idx == 1) ? 60 : 4 + int'($urandom % 57);
		// x in [-2, 0.5], y in [0, 1.2]
		x = -two_fx + longint'($urandom % 32'd20971521);
		y = longint'($urandom % 32'd10066330);
		dxv = longint'(`DX_BASE) >> z;
		dyv = longint'(`DY_BASE) >> z;
		test_name = $sformatf("frame%0d x=%0d y=%0d zoom=%0d iter=%0d", idx, x, y, z, limit);
		fill_expected(x, y, dxv, dyv, limit);
		foreach (seen[i])
			seen[i] = 1'b0;
		writes = 0;

		@(negedge CLOCK_50);
		x_init   = coord_t'(x);
		y_init   = coord_t'(y);
		zoom     = `ZOOM_W'(z);
		max_iter = iter_t'(limit);
		start    = 1'b1;
		wd_limit = frame_px * (limit + 8) * 2;
		frame_id = idx + 1;
		@(negedge CLOCK_50);
		start = 1'b0;
		// Edge that sampled start counts as one
		measured = 1;
		while (done !== 1'b1) begin
			if (fb_we === 1'b1) begin
				if (fb_addr >= fb_addr_t'(frame_px))
					stop_with_failure($sformatf("%s wrote address %0d outside the frame",
						test_name, fb_addr));
				if (seen[fb_addr])
					stop_with_failure($sformatf("%s wrote address %0d twice",
						test_name, fb_addr));
				seen[fb_addr] = 1'b1;
				writes++;
				check_color($sformatf("%s addr %0d", test_name, fb_addr),
					expected_color[fb_addr], fb_data);
			end
			@(negedge CLOCK_50);
			measured++;
		end
		if (fb_we === 1'b1)
			stop_with_failure($sformatf("%s wrote in the cycle done rose", test_name));
		check_addr({test_name, " writes"}, fb_addr_t'(frame_px), fb_addr_t'(writes));
		check_cycles({test_name, " cycles"}, `TIMER_W'(measured), frame_cycles);

		// Done and timer hold, port stays quiet
		repeat (10) begin
			@(negedge CLOCK_50);
			if (done !== 1'b1)
				stop_with_failure($sformatf("%s done fell without a new start", test_name));
			if (fb_we === 1'b1)
				stop_with_failure($sformatf("%s wrote after done", test_name));
			check_cycles({test_name, " held cycles"}, `TIMER_W'(measured), frame_cycles);
		end
	endtask

	// ========================================
	// Watchdog
	// ========================================
	initial begin : watchdog
		int unsigned seen_id;
		int unsigned waited;
		seen_id = 0;
		waited = 0;
		forever begin
			@(posedge CLOCK_50);
			if (frame_id != seen_id) begin
				seen_id = frame_id;
				waited = 0;
			end else begin
				waited++;
			end
			if (waited > wd_limit) begin
				$display("Frame %0d never finished within %0d cycles", frame_id, wd_limit);
				$display("Something failed");
				$fatal(1, "Watchdog timeout");
			end
		end
	end

	// Main sequence
	initial begin
		start     = 1'b0;
		x_init    = '0;
		y_init    = '0;
		zoom      = '0;
		max_iter  = iter_t'(4);
		frame_id  = 0;
		// Covers reset and the idle window
		wd_limit  = 100;
		test_name = "idle";
		void'($urandom(73800));
		wait (arst_n === 1'b1);
		idle_check();
		for (int i = 0; i < n_frames; i++)
			render_frame(i);
		$display("Everything OK");
		$finish;
	end

endmodule

/* hw/fixed_pkg.sv */
`include "mandel_consts.svh"

package fixed_pkg;

	// ========================================
	// Fixed-point number types
	// ========================================

	// Point coordinate
	// 4 integer bits with sign, 23 fraction bits
	// Sums and products wrap modulo 2^27
	typedef logic signed [`COORD_W-1:0] coord_t;

	// Iteration count and limit
	// Same width as a coordinate word
	typedef logic [`COORD_W-1:0] iter_t;

endpackage

/* hw/frame_writer.sv */
`timescale 1ns/1ps
`include "mandel_consts.svh"

module frame_writer (
	input  logic                CLOCK_50,
	input  logic                arst_n,
	input  logic                start,
	input  pixel_pkg::fb_addr_t frame_w,
	input  pixel_pkg::fb_addr_t frame_h,
	input  logic                empty,
	input  pixel_pkg::pixel_t   pop_data,
	output logic                pop,
	output logic                fb_we,
	output pixel_pkg::fb_addr_t fb_addr,
	output pixel_pkg::color_t   fb_data,
	output logic                done,
	output logic [`TIMER_W-1:0] frame_cycles
);
	import pixel_pkg::*;

	fb_addr_t total;
	fb_addr_t written;
	logic     running;
	logic     last_write;

	// Drain the FIFO whenever it holds a word
	assign pop        = !empty;
	assign total      = frame_w * frame_h;
	assign last_write = fb_we && (written == total - 1'b1);

	// ========================================
	// Write count, frame timer, done
	// ========================================
	always_ff @(posedge CLOCK_50 or negedge arst_n) begin
		if (!arst_n) begin
			fb_we        <= 1'b0;
			written      <= '0;
			running      <= 1'b0;
			done         <= 1'b0;
			frame_cycles <= '0;
		end else begin
			fb_we <= pop;
			if (start) begin
				// Start edge is the first counted edge
				written      <= '0;
				running      <= 1'b1;
				done         <= 1'b0;
				frame_cycles <= 1;
			end else begin
				if (fb_we)
					written <= written + 1'b1;
				if (running) begin
					frame_cycles <= frame_cycles + 1'b1;
					// Done rises the edge after the last strobe
					if (last_write) begin
						running <= 1'b0;
						done    <= 1'b1;
					end
				end
			end
		end
	end

	// Popped word goes straight onto the write port
	always_ff @(posedge CLOCK_50) begin
		if (pop) begin
			fb_addr <= pop_data.addr;
			fb_data <= pop_data.color;
		end
	end

	a_quiet_done: assert property (@(posedge CLOCK_50) disable iff (!arst_n) done |-> !fb_we);

endmodule

/* hw/lane_arbiter.sv */
`timescale 1ns/1ps
`include "mandel_consts.svh"

module lane_arbiter #(
	parameter int lanes = `LANES
) (
	input  logic               CLOCK_50,
	input  logic               arst_n,
	input  logic [lanes-1:0]   pix_valid,
	input  pixel_pkg::pixel_t  pix [lanes],
	input  logic               full,
	output logic [lanes-1:0]   ack,
	output logic               push,
	output pixel_pkg::pixel_t  push_data
);
	localparam int ptr_w = (lanes > 1) ? $clog2(lanes) : 1;

	// Search starts just after the last lane granted
	logic [ptr_w-1:0] last_q;
	logic [ptr_w-1:0] pick;
	logic             found;

	always_comb begin
		int idx;
		found = 1'b0;
		pick  = last_q;
		for (int i = 1; i <= lanes; i++) begin
			idx = (int'(last_q) + i) % lanes;
			if (!found && pix_valid[idx]) begin
				found = 1'b1;
				pick  = ptr_w'(idx);
			end
		end
	end

	// Nothing granted while the FIFO is full
	assign push      = found && !full;
	assign ack       = push ? (lanes'(1) << pick) : '0;
	assign push_data = pix[pick];

	always_ff @(posedge CLOCK_50 or negedge arst_n) begin
		if (!arst_n)
			last_q <= ptr_w'(lanes - 1);
		else if (push)
			last_q <= pick;
	end

	// Granted lane drops its request before it can be acked again
	a_ack_once: assert property (@(posedge CLOCK_50) disable iff (!arst_n)
		|ack |=> (ack & $past(ack)) == '0);

endmodule

/* hw/mandel_consts.svh */
`ifndef MANDEL_CONSTS_SVH
`define MANDEL_CONSTS_SVH

// ========================================
// Number format, signed 4.23
// ========================================
`define COORD_W    27
`define FRAC_BITS  23
// Pixel steps at zoom 0, about 0.0047 and 0.0042
`define DX_BASE    27'h0009999
`define DY_BASE    27'h0008888

// ========================================
// Frame, lanes and buffering
// ========================================
`define FRAME_W    640
`define FRAME_H    480
`define LANES      6
`define FIFO_DEPTH 4
`define ADDR_W     19
`define COLOR_W    8
`define ZOOM_W     4
`define TIMER_W    32

// RGB332 bands, black inside the set
`define PAL_BLACK  8'b000_000_00
`define PAL_BAND1  8'b011_001_00
`define PAL_BAND2  8'b011_001_00
`define PAL_BAND3  8'b101_010_01
`define PAL_BAND4  8'b011_001_01
`define PAL_BAND5  8'b001_001_01
`define PAL_BAND6  8'b011_010_10
`define PAL_BAND7  8'b010_100_10
`define PAL_BAND8  8'b010_100_10

`endif

/* hw/mandel_core.sv */
`timescale 1ns/1ps
`include "mandel_consts.svh"

module mandel_core (
	input  logic              CLOCK_50,
	input  logic              arst_n,
	input  logic              go,
	input  fixed_pkg::coord_t cr,
	input  fixed_pkg::coord_t ci,
	input  fixed_pkg::iter_t  max_iter,
	output logic              finished,
	output fixed_pkg::iter_t  count
);
	import fixed_pkg::*;

	// Escape limits, 4.0 and 2.0 in 4.23
	localparam int four_fx = 4 << `FRAC_BITS;
	localparam int two_fx  = 2 << `FRAC_BITS;

	coord_t zr;
	coord_t zi;
	iter_t  iter;
	logic   busy;

	// Full-width products, then truncated back to 4.23
	logic signed [2*`COORD_W-1:0] zr_zr_full;
	logic signed [2*`COORD_W-1:0] zi_zi_full;
	logic signed [2*`COORD_W-1:0] zr_zi_full;
	coord_t zr_sq;
	coord_t zi_sq;
	coord_t zr_zi;
	// One extra bit so |z|^2 up to 8 cannot wrap
	logic signed [`COORD_W:0] mag_sq;
	logic escape;

	assign zr_zr_full = zr * zr;
	assign zi_zi_full = zi * zi;
	assign zr_zi_full = zr * zi;
	// Same as >>> FRAC_BITS and keeping the low word
	assign zr_sq = zr_zr_full[`FRAC_BITS +: `COORD_W];
	assign zi_sq = zi_zi_full[`FRAC_BITS +: `COORD_W];
	assign zr_zi = zr_zi_full[`FRAC_BITS +: `COORD_W];
	assign mag_sq = zr_sq + zi_sq;

	// Stop on radius, on either axis leaving [-2,2), or at the limit
	assign escape = (mag_sq >= four_fx) || (zr >= two_fx) || (zr <= -two_fx) ||
		(zi >= two_fx) || (zi <= -two_fx) || (iter == max_iter);

	// Busy from the edge after go until finished rises
	always_ff @(posedge CLOCK_50 or negedge arst_n) begin
		if (!arst_n) begin
			busy     <= 1'b0;
			finished <= 1'b0;
		end else begin
			finished <= 1'b0;
			if (go) begin
				busy <= 1'b1;
			end else if (busy && escape) begin
				busy     <= 1'b0;
				finished <= 1'b1;
			end
		end
	end

	// One z step per clock, count captured on the last one
	always_ff @(posedge CLOCK_50) begin
		if (go) begin
			zr   <= '0;
			zi   <= '0;
			iter <= '0;
		end else if (busy) begin
			if (escape) begin
				count <= iter;
			end else begin
				zr   <= zr_sq - zi_sq + cr;
				zi   <= (zr_zi <<< 1) + ci;
				iter <= iter + 1'b1;
			end
		end
	end

	// Lane must wait for finished before the next go
	a_go_idle: assert property (@(posedge CLOCK_50) disable iff (!arst_n) go |-> !busy);

endmodule

/* hw/mandel_lane.sv */
`timescale 1ns/1ps
`include "mandel_consts.svh"

module mandel_lane #(
	parameter int lane_idx = 0,
	parameter int lanes    = `LANES
) (
	input  logic                CLOCK_50,
	input  logic                arst_n,
	input  logic                start,
	input  fixed_pkg::coord_t   x_init,
	input  fixed_pkg::coord_t   y_init,
	input  fixed_pkg::coord_t   dx,
	input  fixed_pkg::coord_t   dy,
	input  fixed_pkg::iter_t    max_iter,
	input  pixel_pkg::fb_addr_t frame_w,
	input  pixel_pkg::fb_addr_t frame_h,
	input  logic                ack,
	output logic                pix_valid,
	output pixel_pkg::pixel_t   pix,
	output logic                lane_done
);
	import fixed_pkg::*;
	import pixel_pkg::*;

	typedef enum logic [2:0] {
		st_idle, st_setup1, st_setup2, st_run, st_wait_ack, st_done
	} state_t;

	state_t   state;
	fb_addr_t col;
	fb_addr_t row;
	fb_addr_t row_base;
	coord_t   cr;
	coord_t   ci;
	logic     go;
	logic     core_done;
	iter_t    core_count;
	logic     advance;
	logic     last_col;
	logic     last_row;
	logic     has_rows;

	// Offsets of the first row and per-row steps for this lane
	coord_t   ci_first;
	coord_t   ci_step;
	fb_addr_t base_first;
	fb_addr_t base_step;

	assign ci_first   = coord_t'(lane_idx) * dy;
	assign ci_step    = coord_t'(lanes) * dy;
	assign base_first = fb_addr_t'(lane_idx) * frame_w;
	assign base_step  = fb_addr_t'(lanes) * frame_w;

	assign has_rows = fb_addr_t'(lane_idx) < frame_h;
	assign last_col = col == frame_w - 1'b1;
	assign last_row = row + fb_addr_t'(lanes) >= frame_h;
	assign advance  = (state == st_wait_ack) && ack;
	assign go       = state == st_setup2;

	// First matching band wins
	function automatic color_t band(input iter_t n, input iter_t lim);
		color_t c;
		if (n >= lim) c = `PAL_BLACK;
		else if (n >= (lim >> 1)) c = `PAL_BAND1;
		else if (n >= (lim >> 2)) c = `PAL_BAND2;
		else if (n >= (lim >> 3)) c = `PAL_BAND3;
		else if (n >= (lim >> 4)) c = `PAL_BAND4;
		else if (n >= (lim >> 5)) c = `PAL_BAND5;
		else if (n >= (lim >> 6)) c = `PAL_BAND6;
		else if (n >= (lim >> 7)) c = `PAL_BAND7;
		else c = `PAL_BAND8;
		return c;
	endfunction

	// ========================================
	// Pixel walker FSM
	// ========================================
	always_ff @(posedge CLOCK_50 or negedge arst_n) begin
		if (!arst_n) begin
			state     <= st_idle;
			pix_valid <= 1'b0;
			lane_done <= 1'b0;
			col       <= '0;
			row       <= '0;
		end else if (start) begin
			// Restart at this lane's first row
			col       <= '0;
			row       <= fb_addr_t'(lane_idx);
			pix_valid <= 1'b0;
			lane_done <= !has_rows;
			state     <= has_rows ? st_setup1 : st_done;
		end else begin
			case (state)
				st_setup1: state <= st_setup2;
				// go leaves in this state
				st_setup2: state <= st_run;
				st_run: begin
					if (core_done) begin
						pix_valid <= 1'b1;
						state     <= st_wait_ack;
					end
				end
				st_wait_ack: begin
					if (ack) begin
						pix_valid <= 1'b0;
						if (last_col && last_row) begin
							lane_done <= 1'b1;
							state     <= st_done;
						end else begin
							state <= st_setup1;
							if (last_col) begin
								col <= '0;
								row <= row + fb_addr_t'(lanes);
							end else begin
								col <= col + 1'b1;
							end
						end
					end
				end
				default: state <= state;
			endcase
		end
	end

	// Point and pixel datapath, stepped by addition
	always_ff @(posedge CLOCK_50) begin
		if (start) begin
			cr       <= x_init;
			ci       <= y_init - ci_first;
			row_base <= base_first;
		end else if (advance) begin
			if (last_col) begin
				// Next row of this lane, lanes rows down
				cr       <= x_init;
				ci       <= ci - ci_step;
				row_base <= row_base + base_step;
			end else begin
				cr <= cr + dx;
			end
		end
		if (state == st_setup1)
			pix.addr <= row_base + col;
		if (core_done)
			pix.color <= band(core_count, max_iter);
	end

	mandel_core u_core (
		.CLOCK_50 (CLOCK_50),
		.arst_n   (arst_n),
		.go       (go),
		.cr       (cr),
		.ci       (ci),
		.max_iter (max_iter),
		.finished (core_done),
		.count    (core_count)
	);

	// Request and pixel held until the arbiter acks
	a_hold: assert property (@(posedge CLOCK_50) disable iff (!arst_n)
		pix_valid && !ack && !start |=> pix_valid && $stable(pix));

endmodule

/* hw/mandel_top.sv */
`timescale 1ns/1ps
`include "mandel_consts.svh"

module mandel_top #(
	parameter int frame_w = `FRAME_W,
	parameter int frame_h = `FRAME_H,
	parameter int lanes   = `LANES
) (
	input  logic                CLOCK_50,
	input  logic                arst_n,
	input  logic                start,
	input  fixed_pkg::coord_t   x_init,
	input  fixed_pkg::coord_t   y_init,
	input  logic [`ZOOM_W-1:0]  zoom,
	input  fixed_pkg::iter_t    max_iter,
	output logic                fb_we,
	output pixel_pkg::fb_addr_t fb_addr,
	output pixel_pkg::color_t   fb_data,
	output logic                done,
	output logic [`TIMER_W-1:0] frame_cycles
);
	import fixed_pkg::*;
	import pixel_pkg::*;

	localparam fb_addr_t width_px  = fb_addr_t'(frame_w);
	localparam fb_addr_t height_px = fb_addr_t'(frame_h);

	coord_t dx;
	coord_t dy;
	logic [lanes-1:0] lane_valid;
	logic [lanes-1:0] lane_ack;
	logic [lanes-1:0] lane_done;
	pixel_t lane_pix [lanes];
	logic   push;
	pixel_t push_data;
	logic   pop;
	pixel_t pop_data;
	logic   full;
	logic   empty;

	// Pixel steps halve with each zoom level
	assign dx = `DX_BASE >> zoom;
	assign dy = `DY_BASE >> zoom;

	// ========================================
	// Lanes, rows interleaved by lane index
	// ========================================
	for (genvar j = 0; j < lanes; j++) begin : g_lane
		mandel_lane #(
			.lane_idx (j),
			.lanes    (lanes)
		) u_lane (
			.CLOCK_50  (CLOCK_50),
			.arst_n    (arst_n),
			.start     (start),
			.x_init    (x_init),
			.y_init    (y_init),
			.dx        (dx),
			.dy        (dy),
			.max_iter  (max_iter),
			.frame_w   (width_px),
			.frame_h   (height_px),
			.ack       (lane_ack[j]),
			.pix_valid (lane_valid[j]),
			.pix       (lane_pix[j]),
			.lane_done (lane_done[j])
		);
	end

	lane_arbiter #(.lanes(lanes)) u_arb (
		.CLOCK_50  (CLOCK_50),
		.arst_n    (arst_n),
		.pix_valid (lane_valid),
		.pix       (lane_pix),
		.full      (full),
		.ack       (lane_ack),
		.push      (push),
		.push_data (push_data)
	);

	pixel_fifo #(.depth(`FIFO_DEPTH)) u_fifo (
		.CLOCK_50  (CLOCK_50),
		.arst_n    (arst_n),
		.push      (push),
		.push_data (push_data),
		.pop       (pop),
		.pop_data  (pop_data),
		.full      (full),
		.empty     (empty)
	);

	frame_writer u_writer (
		.CLOCK_50     (CLOCK_50),
		.arst_n       (arst_n),
		.start        (start),
		.frame_w      (width_px),
		.frame_h      (height_px),
		.empty        (empty),
		.pop_data     (pop_data),
		.pop          (pop),
		.fb_we        (fb_we),
		.fb_addr      (fb_addr),
		.fb_data      (fb_data),
		.done         (done),
		.frame_cycles (frame_cycles)
	);

	// Frame only completes once every lane walked its last row
	a_lanes_first: assert property (@(posedge CLOCK_50) disable iff (!arst_n)
		$rose(done) |-> &lane_done);

endmodule

/* hw/pixel_fifo.sv */
`timescale 1ns/1ps
`include "mandel_consts.svh"

module pixel_fifo #(
	parameter int depth = `FIFO_DEPTH
) (
	input  logic              CLOCK_50,
	input  logic              arst_n,
	input  logic              push,
	input  pixel_pkg::pixel_t push_data,
	input  logic              pop,
	output pixel_pkg::pixel_t pop_data,
	output logic              full,
	output logic              empty
);
	import pixel_pkg::*;

	localparam int ptr_w = (depth > 1) ? $clog2(depth) : 1;

	pixel_t           mem [depth];
	logic [ptr_w-1:0] wr_ptr;
	logic [ptr_w-1:0] rd_ptr;
	// Occupancy, 0 to depth
	logic [ptr_w:0]   used;

	// Wrap at depth, need not be a power of two
	function automatic logic [ptr_w-1:0] next_ptr(input logic [ptr_w-1:0] p);
		return (p == ptr_w'(depth - 1)) ? '0 : p + 1'b1;
	endfunction

	assign full  = used == depth;
	assign empty = used == 0;
	// Head word shown without a read cycle
	assign pop_data = mem[rd_ptr];

	always_ff @(posedge CLOCK_50 or negedge arst_n) begin
		if (!arst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			used   <= '0;
		end else begin
			if (push)
				wr_ptr <= next_ptr(wr_ptr);
			if (pop)
				rd_ptr <= next_ptr(rd_ptr);
			if (push && !pop)
				used <= used + 1'b1;
			else if (pop && !push)
				used <= used - 1'b1;
		end
	end

	always_ff @(posedge CLOCK_50) begin
		if (push)
			mem[wr_ptr] <= push_data;
	end

	a_no_overflow: assert property (@(posedge CLOCK_50) disable iff (!arst_n) push |-> !full);
	a_no_underflow: assert property (@(posedge CLOCK_50) disable iff (!arst_n) pop |-> !empty);

endmodule

/* hw/pixel_pkg.sv */
`include "mandel_consts.svh"

package pixel_pkg;

	// ========================================
	// Pixel and framebuffer types
	// ========================================

	// RGB332 colour, 3 red 3 green 2 blue
	typedef logic [`COLOR_W-1:0] color_t;

	// Framebuffer word address, row * width + col
	typedef logic [`ADDR_W-1:0] fb_addr_t;

	// One finished pixel on its way to the framebuffer
	typedef struct packed {
		fb_addr_t addr;
		color_t   color;
	} pixel_t;

endpackage

/* project.f */
+incdir+hw
hw/fixed_pkg.sv
hw/pixel_pkg.sv
hw/mandel_core.sv
hw/mandel_lane.sv
hw/lane_arbiter.sv
hw/pixel_fifo.sv
hw/frame_writer.sv
hw/mandel_top.sv
bench/tb_clock.sv
bench/tb_mandel.sv
